// File: build.f
+incdir+source
source/input_pkg.sv
source/state_if.sv
source/key_decoder.sv
source/joystick_sampler.sv
source/control_merger.sv
source/input_top.sv
tests/input_top_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log &&
  verilator --binary --assert -f build.f --top-module input_top_tb -o input_top_tb &&
  ./obj_dir/input_top_tb | tee sim.log &&
  grep -q "ALL CHECKS PASSED" sim.log && echo "run passed" ||
  { echo "run failed"; exit 1; }

// File: tests/input_stimulus.txt
# K pressed code | J joy0 joy1 | G joy0_xor_mask cycles | H | L | W cycles
# E test_name player_1 player_2 service overrun, all values hex
K 1 75
E first_key_up 200 000 0 0
K 1 50
W 8
E unmapped_code 200 000 0 0
K 1 75
W 8
E repeat_press 200 000 0 0
K 0 75
E up_release 000 000 0 0
K 1 2d
E p2_key_r 000 200 0 0
K 0 2d
E r_release 000 000 0 0
J 010 000
E joy0_button_1 020 000 0 0
G 001 3
W 12
E joy_glitch 020 000 0 0
K 1 14
W 8
E key_and_joy 020 000 0 0
J 000 200
E joy_off_key_held 020 001 0 0
K 1 4d
E p_key_p1_only 021 001 0 0
K 1 46
E service_9 021 001 2 0
K 1 45
E service_0 021 001 3 0
L
K 1 75
K 1 72
W 10
H
E backpressure 321 001 3 1

// File: tests/input_top_tb.sv
`timescale 1ns/1ps
`include "input_settings.svh"

module input_top_tb;

  localparam int NAME_W = 8 * 24;

  logic                    clk_sys = 1'b0;
  logic                    rst_n;
  logic [`PS2_EVENT_W-1:0] ps2_key;
  logic [`JOY_W-1:0]       joystick_0;
  logic [`JOY_W-1:0]       joystick_1;
  logic                    ctrl_valid;
  logic                    ctrl_ready;
  input_pkg::player_t      player_1;
  input_pkg::player_t      player_2;
  input_pkg::service_t     service;
  logic                    overrun;

  // Last snapshot taken by a transfer
  input_pkg::player_t  last_p1 = '0;
  input_pkg::player_t  last_p2 = '0;
  input_pkg::service_t last_svc = '0;
  int                  xfer_count = 0;
  // A snapshot waited at the previous edge
  logic                held = 1'b0;

  int errors = 0;
  int monitor_errors = 0;
  int checks = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  input_top i_input_top (
    .clk_sys    (clk_sys),
    .rst_n      (rst_n),
    .ps2_key    (ps2_key),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .ctrl_valid (ctrl_valid),
    .ctrl_ready (ctrl_ready),
    .player_1   (player_1),
    .player_2   (player_2),
    .service    (service),
    .overrun    (overrun)
  );

  // 8 ns clock
  always #4 clk_sys = ~clk_sys;

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_player(input string test, input string label,
                              input input_pkg::player_t exp, input input_pkg::player_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s %s expected %h actual %h", test, label, exp, act);
    end
  endtask

  task automatic check_service(input string test, input input_pkg::service_t exp,
                               input input_pkg::service_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s service expected %h actual %h", test, exp, act);
    end
  endtask

  task automatic check_flag(input string test, input string label, input logic exp,
                            input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s %s expected %b actual %b", test, label, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor and run limit
  ////////////////////////////////////////////////////////////////////////////

  // Values read here are the ones present at the edge
  always @(posedge clk_sys) begin
    if (rst_n && ctrl_valid && ctrl_ready) begin
      last_p1    <= player_1;
      last_p2    <= player_2;
      last_svc   <= service;
      xfer_count <= xfer_count + 1;
    end
    // Offered snapshot must wait for ctrl_ready
    if (held && !ctrl_valid) begin
      monitor_errors <= monitor_errors + 1;
      $display("ctrl_valid fell while a snapshot still waited for ctrl_ready");
    end
    held <= rst_n && ctrl_valid && !ctrl_ready;
  end

  always @(posedge clk_sys) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles before the stimulus ended", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run_stimulus
    int                                     fd;
    int                                     r;
    int                                     line_count;
    int                                     wait_n;
    int                                     mark;
    logic                                   done;
    logic                                   toggle;
    logic                                   pressed;
    logic [7:0]                             cmd;
    logic [7:0]                             last_cmd;
    logic [`KEY_CODE_W-1:0]                 code;
    logic [`JOY_W-1:0]                      j0;
    logic [`JOY_W-1:0]                      j1;
    logic [`PS2_EVENT_W-1:0]                ev;
    logic [NAME_W-1:0]                      name;
    logic [8*128-1:0]                       line;
    logic [$bits(input_pkg::player_t)-1:0]  exp_p1;
    logic [$bits(input_pkg::player_t)-1:0]  exp_p2;
    logic [$bits(input_pkg::service_t)-1:0] exp_svc;
    logic                                   exp_ovr;
    string                                  test;

    rst_n      = 1'b0;
    ps2_key    = '0;
    joystick_0 = '0;
    joystick_1 = '0;
    ctrl_ready = 1'b1;

    // Run limit scales with the file length
    line_count = 0;
    fd = $fopen("tests/input_stimulus.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0)
        line_count++;
      $fclose(fd);
    end
    cycle_limit = 16 + line_count * (`DEBOUNCE_CYCLES + 20);

    repeat (16) @(posedge clk_sys);
    rst_n <= 1'b1;

    // Nothing offered before the first event
    repeat (4) begin
      @(negedge clk_sys);
      check_flag("reset_idle", "ctrl_valid", 1'b0, ctrl_valid);
      check_flag("reset_idle", "overrun", 1'b0, overrun);
    end

    fd = $fopen("tests/input_stimulus.txt", "r");
    done = (fd == 0);
    if (fd == 0) begin
      errors++;
      $display("The stimulus file tests/input_stimulus.txt could not be opened");
    end
    toggle   = 1'b0;
    mark     = xfer_count;
    last_cmd = "#";

    while (!done) begin
      r = $fscanf(fd, "%s", cmd);
      if (r != 1) begin
        done = 1'b1;
      end else begin
        case (cmd)
          "#": r = $fgets(line, fd);
          "K": begin
            r = $fscanf(fd, "%h %h", pressed, code);
            // Each event flips the toggle bit
            toggle = ~toggle;
            ev = '0;
            ev[`PS2_EVENT_W-1]   = toggle;
            ev[`PS2_EVENT_W-2]   = pressed;
            ev[`KEY_CODE_W-1:0] = code;
            @(posedge clk_sys);
            ps2_key <= ev;
          end
          "J": begin
            r = $fscanf(fd, "%h %h", j0, j1);
            @(posedge clk_sys);
            joystick_0 <= j0;
            joystick_1 <= j1;
          end
          "G": begin
            // Flip joystick_0 bits for a few samples, then restore
            r = $fscanf(fd, "%h %d", j0, wait_n);
            @(posedge clk_sys);
            joystick_0 <= joystick_0 ^ j0;
            repeat (wait_n) @(posedge clk_sys);
            joystick_0 <= joystick_0 ^ j0;
          end
          "H": begin
            @(posedge clk_sys);
            ctrl_ready <= 1'b1;
          end
          "L": begin
            @(posedge clk_sys);
            ctrl_ready <= 1'b0;
          end
          "W": begin
            r = $fscanf(fd, "%d", wait_n);
            repeat (wait_n) @(posedge clk_sys);
          end
          "E": begin
            r = $fscanf(fd, "%s %h %h %h %h", name, exp_p1, exp_p2, exp_svc, exp_ovr);
            test = $sformatf("%0s", name);
            @(negedge clk_sys);
            // After a wait no new snapshot may arrive, else wait for one
            if (last_cmd == "W") begin
              if (xfer_count != mark) begin
                errors++;
                $display("%s: a snapshot was delivered where none was expected", test);
              end
            end else begin
              while (xfer_count == mark)
                @(negedge clk_sys);
            end
            check_player(test, "player_1", exp_p1, last_p1);
            check_player(test, "player_2", exp_p2, last_p2);
            check_service(test, exp_svc, last_svc);
            check_flag(test, "overrun", exp_ovr, overrun);
            mark = xfer_count;
          end
          default: begin
            errors++;
            $display("Unknown stimulus command %s, stopping the stimulus", cmd);
            done = 1'b1;
          end
        endcase
        if (cmd != "#")
          last_cmd = cmd;
      end
    end
    if (fd != 0)
      $fclose(fd);

    errors = errors + monitor_errors;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: source/input_top.sv
`timescale 1ns/1ps
`include "input_settings.svh"

module input_top (
  input  logic                    clk_sys,
  input  logic                    rst_n,
  input  logic [`PS2_EVENT_W-1:0] ps2_key,
  input  logic [`JOY_W-1:0]       joystick_0,
  input  logic [`JOY_W-1:0]       joystick_1,
  output logic                    ctrl_valid,
  input  logic                    ctrl_ready,
  output input_pkg::player_t      player_1,
  output input_pkg::player_t      player_2,
  output input_pkg::service_t     service,
  output logic                    overrun
);

  // Links from the two decoders into the merger
  state_if #(.payload_t(input_pkg::key_state_t)) key_link ();
  state_if #(.payload_t(input_pkg::joy_state_t)) joy_link ();

  key_decoder i_key_decoder (
    .clk_sys (clk_sys),
    .rst_n   (rst_n),
    .ps2_key (ps2_key),
    .key_out (key_link.source)
  );

  joystick_sampler i_joystick_sampler (
    .clk_sys    (clk_sys),
    .rst_n      (rst_n),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .joy_out    (joy_link.source)
  );

  control_merger i_control_merger (
    .clk_sys    (clk_sys),
    .rst_n      (rst_n),
    .key_in     (key_link.sink),
    .joy_in     (joy_link.sink),
    .ctrl_valid (ctrl_valid),
    .ctrl_ready (ctrl_ready),
    .player_1   (player_1),
    .player_2   (player_2),
    .service    (service),
    .overrun    (overrun)
  );

endmodule

// File: source/control_merger.sv
`timescale 1ns/1ps
`include "input_settings.svh"

module control_merger (
  input  logic                clk_sys,
  input  logic                rst_n,
  state_if.sink               key_in,
  state_if.sink               joy_in,
  output logic                ctrl_valid,
  input  logic                ctrl_ready,
  output input_pkg::player_t  player_1,
  output input_pkg::player_t  player_2,
  output input_pkg::service_t service,
  output logic                overrun
);

  // Last accepted source words
  input_pkg::key_state_t key_q;
  input_pkg::joy_state_t joy_q;

  // Newest source words taken straight from a beat on the accepting edge
  input_pkg::key_state_t key_now;
  input_pkg::joy_state_t joy_now;

  input_pkg::player_t  p1_keys;
  input_pkg::player_t  p2_keys;
  input_pkg::player_t  merged_p1;
  input_pkg::player_t  merged_p2;
  input_pkg::service_t merged_svc;
  logic                key_take;
  logic                joy_take;
  logic                snap_change;

  // Port bit order into player field order
  function automatic input_pkg::player_t joy_to_player(input logic [`JOY_W-1:0] j);
    input_pkg::player_t p;
    p.right    = j[0];
    p.left     = j[1];
    p.down     = j[2];
    p.up       = j[3];
    p.button_1 = j[4];
    p.button_2 = j[5];
    p.button_3 = j[6];
    p.start    = j[7];
    p.coin     = j[8];
    p.pause    = j[9];
    return p;
  endfunction

  // Never back-pressure the sources
  assign key_in.ready = 1'b1;
  assign joy_in.ready = 1'b1;

  assign key_take = key_in.valid && key_in.ready;
  assign joy_take = joy_in.valid && joy_in.ready;
  assign key_now  = key_take ? key_in.data : key_q;
  assign joy_now  = joy_take ? joy_in.data : joy_q;

  ////////////////////////////////////////////////////////////////////////////
  // Key to player mapping
  ////////////////////////////////////////////////////////////////////////////

  assign p1_keys = '{up: key_now.up, down: key_now.down, left: key_now.left,
                     right: key_now.right, button_1: key_now.ctrl,
                     button_2: key_now.alt, button_3: key_now.space,
                     start: key_now.num_1, coin: key_now.num_5, pause: key_now.p};

  // Player 2 pause has no key
  assign p2_keys = '{up: key_now.r, down: key_now.f, left: key_now.d,
                     right: key_now.g, button_1: key_now.a, button_2: key_now.s,
                     button_3: key_now.q, start: key_now.num_2,
                     coin: key_now.num_6, pause: 1'b0};

  assign merged_p1  = p1_keys | joy_to_player(joy_now.joystick_0);
  assign merged_p2  = p2_keys | joy_to_player(joy_now.joystick_1);
  assign merged_svc = '{service_1: key_now.num_9, service_2: key_now.num_0};

  assign snap_change = (key_take || joy_take) &&
                       ({merged_p1, merged_p2, merged_svc} != {player_1, player_2, service});

  ////////////////////////////////////////////////////////////////////////////
  // Offered snapshot
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      key_q      <= '0;
      joy_q      <= '0;
      player_1   <= '0;
      player_2   <= '0;
      service    <= '0;
      ctrl_valid <= 1'b0;
      overrun    <= 1'b0;
    end else begin
      if (key_take)
        key_q <= key_in.data;
      if (joy_take)
        joy_q <= joy_in.data;
      if (snap_change) begin
        player_1   <= merged_p1;
        player_2   <= merged_p2;
        service    <= merged_svc;
        ctrl_valid <= 1'b1;
      end else if (ctrl_valid && ctrl_ready) begin
        ctrl_valid <= 1'b0;
      end
      // Sticky flag set by a replaced snapshot or a word lost upstream
      if (snap_change && ctrl_valid && !ctrl_ready)
        overrun <= 1'b1;
      if ((key_take && key_in.dropped) || (joy_take && joy_in.dropped))
        overrun <= 1'b1;
    end
  end

  // A waiting snapshot stays offered and only moves when overrun marks it replaced
  a_snapshot_held : assert property (@(posedge clk_sys) disable iff (!rst_n)
    ctrl_valid && !ctrl_ready
    |=> ctrl_valid && (overrun || $stable({player_1, player_2, service})));

endmodule

// File: source/joystick_sampler.sv
`timescale 1ns/1ps
`include "input_settings.svh"

module joystick_sampler (
  input  logic              clk_sys,
  input  logic              rst_n,
  input  logic [`JOY_W-1:0] joystick_0,
  input  logic [`JOY_W-1:0] joystick_1,
  state_if.source           joy_out
);

  localparam int DEB   = `DEBOUNCE_CYCLES;
  localparam int CNT_W = $clog2(DEB + 1);

  // Index 0 is joystick_0, index 1 is joystick_1
  logic [1:0][`JOY_W-1:0] port_in;
  logic [1:0][`JOY_W-1:0] sync_1;
  logic [1:0][`JOY_W-1:0] sync_2;
  logic [1:0][`JOY_W-1:0] prev_q;
  logic [1:0][`JOY_W-1:0] deb_q;
  logic [1:0][CNT_W-1:0]  cnt_q;
  logic [1:0][CNT_W-1:0]  stable_n;
  logic [1:0]             accept;

  assign port_in = {joystick_1, joystick_0};

  // Samples seen so far including this edge, restarted on any change
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      if (sync_2[p] != prev_q[p])
        stable_n[p] = CNT_W'(1);
      else if (cnt_q[p] < CNT_W'(DEB))
        stable_n[p] = cnt_q[p] + 1'b1;
      else
        stable_n[p] = cnt_q[p];
      accept[p] = (stable_n[p] >= CNT_W'(DEB)) && (sync_2[p] != deb_q[p]);
    end
  end

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      sync_1          <= '0;
      sync_2          <= '0;
      prev_q          <= '0;
      deb_q           <= '0;
      cnt_q           <= '0;
      joy_out.valid   <= 1'b0;
      joy_out.dropped <= 1'b0;
    end else begin
      // Two flop synchroniser, then one stable count per port
      sync_1 <= port_in;
      sync_2 <= sync_1;
      prev_q <= sync_2;
      cnt_q  <= stable_n;
      for (int p = 0; p < 2; p++) begin
        if (accept[p])
          deb_q[p] <= sync_2[p];
      end
      if (|accept) begin
        joy_out.valid   <= 1'b1;
        joy_out.dropped <= joy_out.valid && !joy_out.ready;
      end else if (joy_out.valid && joy_out.ready) begin
        joy_out.valid   <= 1'b0;
        joy_out.dropped <= 1'b0;
      end
    end
  end

  assign joy_out.data = '{joystick_0: deb_q[0], joystick_1: deb_q[1]};

  // Waiting word only moves when it is marked as replaced
  a_data_held : assert property (@(posedge clk_sys) disable iff (!rst_n)
    joy_out.valid && !joy_out.ready && !joy_out.dropped
    |=> joy_out.dropped || $stable(joy_out.data));

endmodule

// File: source/key_decoder.sv
`timescale 1ns/1ps
`include "input_settings.svh"

module key_decoder (
  input  logic                    clk_sys,
  input  logic                    rst_n,
  input  logic [`PS2_EVENT_W-1:0] ps2_key,
  state_if.source                 key_out
);

  // Event word fields
  logic                   toggle;
  logic                   pressed;
  logic [`KEY_CODE_W-1:0] code;

  // Previous toggle, a difference marks a new event
  logic toggle_q;

  input_pkg::key_state_t key_state_q;
  input_pkg::key_state_t key_mask;
  input_pkg::key_state_t key_next;
  logic                  new_event;
  logic                  update;

  assign toggle  = ps2_key[`PS2_EVENT_W-1];
  assign pressed = ps2_key[`PS2_EVENT_W-2];
  assign code    = ps2_key[`KEY_CODE_W-1:0];

  assign new_event = (toggle != toggle_q);

  ////////////////////////////////////////////////////////////////////////////
  // Scan code map
  ////////////////////////////////////////////////////////////////////////////

  // One-hot mask of the key, all zero for an unmapped code
  function automatic input_pkg::key_state_t map_code(input logic [`KEY_CODE_W-1:0] c);
    input_pkg::key_state_t m;
    m = '0;
    case (c)
      8'h75: m.up    = 1'b1;
      8'h72: m.down  = 1'b1;
      8'h6b: m.left  = 1'b1;
      8'h74: m.right = 1'b1;
      8'h14: m.ctrl  = 1'b1;
      8'h11: m.alt   = 1'b1;
      8'h29: m.space = 1'b1;
      8'h16: m.num_1 = 1'b1;
      8'h1e: m.num_2 = 1'b1;
      8'h2e: m.num_5 = 1'b1;
      8'h36: m.num_6 = 1'b1;
      8'h46: m.num_9 = 1'b1;
      8'h45: m.num_0 = 1'b1;
      8'h1c: m.a     = 1'b1;
      8'h1b: m.s     = 1'b1;
      8'h15: m.q     = 1'b1;
      8'h2d: m.r     = 1'b1;
      8'h2b: m.f     = 1'b1;
      8'h23: m.d     = 1'b1;
      8'h34: m.g     = 1'b1;
      8'h4d: m.p     = 1'b1;
      default: m = '0;
    endcase
    return m;
  endfunction

  assign key_mask = map_code(code);
  assign key_next = pressed ? (key_state_q | key_mask) : (key_state_q & ~key_mask);

  // Only a real change of a mapped key becomes a beat
  assign update = new_event && (key_next != key_state_q);

  ////////////////////////////////////////////////////////////////////////////
  // State register and source handshake
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      toggle_q        <= 1'b0;
      key_state_q     <= '0;
      key_out.valid   <= 1'b0;
      key_out.dropped <= 1'b0;
    end else begin
      toggle_q <= toggle;
      if (update) begin
        key_state_q   <= key_next;
        key_out.valid <= 1'b1;
        // Waiting word is overwritten by the newer one
        key_out.dropped <= key_out.valid && !key_out.ready;
      end else if (key_out.valid && key_out.ready) begin
        key_out.valid   <= 1'b0;
        key_out.dropped <= 1'b0;
      end
    end
  end

  assign key_out.data = key_state_q;

  // A waiting beat is never withdrawn
  a_valid_held : assert property (@(posedge clk_sys) disable iff (!rst_n)
    key_out.valid && !key_out.ready |=> key_out.valid);

endmodule

// File: source/state_if.sv
`timescale 1ns/1ps

// Valid/ready link for one held state word
// The same link carries key states and joystick states
interface state_if #(
  parameter type payload_t = logic
) ();

  // Beat offered by the source
  logic     valid;
  // Sink can take the beat this cycle
  logic     ready;
  // Newest state word, held while waiting
  payload_t data;
  // A newer word replaced one that was still waiting
  logic     dropped;

  modport source (
    output valid,
    output data,
    output dropped,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  dropped,
    output ready
  );

endinterface

// File: source/input_pkg.sv
`include "input_settings.svh"

package input_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Source state words
  ////////////////////////////////////////////////////////////////////////////

  // One bit per mapped key, set while the key is held
  // Up is the top bit, p the bottom bit
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic ctrl;
    logic alt;
    logic space;
    logic num_1;
    logic num_2;
    logic num_5;
    logic num_6;
    logic num_9;
    logic num_0;
    logic a;
    logic s;
    logic q;
    logic r;
    logic f;
    logic d;
    logic g;
    logic p;
  } key_state_t;

  // Debounced port words, joystick_0 in the upper half
  typedef struct packed {
    logic [`JOY_W-1:0] joystick_0;
    logic [`JOY_W-1:0] joystick_1;
  } joy_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Merged controls
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic button_1;
    logic button_2;
    logic button_3;
    logic start;
    logic coin;
    logic pause;
  } player_t;

  // Service keys, driven from the keyboard only
  typedef struct packed {
    logic service_1;
    logic service_2;
  } service_t;

endpackage

// File: source/input_settings.svh
`ifndef INPUT_SETTINGS_SVH
`define INPUT_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Keyboard event format
////////////////////////////////////////////////////////////////////////////

// Width of one PS/2 scan code
`define KEY_CODE_W 8

// Event word: bit 10 toggles per event, bit 9 is pressed, 7..0 the code
`define PS2_EVENT_W 11

////////////////////////////////////////////////////////////////////////////
// Joystick ports
////////////////////////////////////////////////////////////////////////////

// Right, left, down, up, three buttons, start, coin, pause from bit 0 up
`define JOY_W 10

// Equal samples needed before a joystick word change is taken
`define DEBOUNCE_CYCLES 4

`endif
